// File: common/sched_cfg_pkg.sv
// --------------------
// scheduler configuration
// sizes of the warp table and the
// basic per-warp types built on them
// --------------------
package sched_cfg_pkg;

    // table sizes
    localparam int NUM_WARPS    = 4;
    localparam int NUM_THREADS  = 4;
    localparam int XLEN         = 32;
    localparam int NUM_BARRIERS = 4;

    // room reserved for ALU branch ports in the update message
    localparam int MAX_BRANCH_PORTS = 2;

    localparam int NW_BITS = $clog2(NUM_WARPS);
    localparam int NB_BITS = $clog2(NUM_BARRIERS);

    typedef logic [NW_BITS-1:0]     wid_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [XLEN-1:0]        pc_t;
    typedef logic [NUM_WARPS-1:0]   wmask_t;
    typedef logic [NB_BITS-1:0]     bar_id_t;

    // member count of one barrier, 0 up to NUM_WARPS
    typedef logic [$clog2(NUM_WARPS+1)-1:0] wcount_t;

endpackage

// File: common/sched_msg_pkg.sv
// --------------------
// scheduler messages
// packed structs for the port events and
// the update passed from decode to the table
// --------------------
package sched_msg_pkg;

    typedef struct packed {
        logic                 valid;
        sched_cfg_pkg::wmask_t wmask;
        sched_cfg_pkg::pc_t    pc;
    } spawn_t;

    typedef struct packed {
        logic                  valid;
        sched_cfg_pkg::tmask_t tmask;
    } tmc_t;

    typedef struct packed {
        logic                             valid;
        sched_cfg_pkg::bar_id_t           id;
        logic [sched_cfg_pkg::NW_BITS-1:0] size_m1;
    } barrier_t;

    // one warp control event, the sub-valids qualify the groups
    typedef struct packed {
        sched_cfg_pkg::wid_t wid;
        spawn_t              spawn;
        tmc_t                tmc;
        barrier_t            barrier;
        logic                valid;
    } warp_ctl_t;

    typedef struct packed {
        logic                valid;
        sched_cfg_pkg::wid_t wid;
        logic                taken;
        sched_cfg_pkg::pc_t  dest;
    } branch_t;

    typedef struct packed {
        logic                valid;
        sched_cfg_pkg::wid_t wid;
        logic                is_wstall;
    } dec_unlock_t;

    typedef struct packed {
        logic                valid;
        sched_cfg_pkg::wid_t wid;
    } commit_t;

    typedef struct packed {
        sched_cfg_pkg::wid_t   wid;
        sched_cfg_pkg::tmask_t tmask;
        sched_cfg_pkg::pc_t    pc;
    } sched_out_t;

    // registered events of one cycle
    typedef struct packed {
        warp_ctl_t                                      ctl;
        branch_t [sched_cfg_pkg::MAX_BRANCH_PORTS-1:0] branch;
        commit_t                                        unlock;
    } warp_update_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# build and run the warp scheduler testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module warp_sched_tb \
    -f sim.f

# a $fatal in the testbench gives a failing exit status
./obj_dir/Vwarp_sched_tb

// File: sim.f
+incdir+tb
common/sched_cfg_pkg.sv
common/sched_msg_pkg.sv
verilog/warp_ctl_decode.sv
warp_table/warp_table.sv
warp_table/barrier_unit.sv
verilog/warp_issue.sv
verilog/pending_instr.sv
verilog/warp_sched.sv
tb/warp_sched_tb.sv

// File: tb/sched_check.svh
// --------------------
// scheduler checks
// typed compare tasks and the stimulus LFSR
// --------------------
`ifndef SCHED_CHECK_SVH
`define SCHED_CHECK_SVH

// fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic fb;
    fb = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], fb};
endfunction

// one issued warp against the model
task automatic compare_out(input sched_msg_pkg::sched_out_t got,
                           input sched_msg_pkg::sched_out_t exp,
                           input string what);
    if (got !== exp) begin
        $display("Error at %0t: %s got wid %0d tmask %b pc %h, expected wid %0d tmask %b pc %h",
                 $time, what, got.wid, got.tmask, got.pc, exp.wid, exp.tmask, exp.pc);
        stop_failed();
    end
endtask

// single flag such as busy or valid
task automatic compare_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
        $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
        stop_failed();
    end
endtask

`endif

// File: tb/warp_sched_tb.sv
// --------------------
// warp scheduler testbench
// table of events applied in a loop with
// each transfer checked against a warp model
// --------------------
`timescale 1ns/1ps

module warp_sched_tb;
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    localparam pc_t BOOT_PC = 32'h8000_0000;
    localparam int  NSTEPS  = 23;
    localparam int  TIMEOUT = 200;

    // step kinds
    localparam logic [2:0] K_IDLE   = 3'd0;
    localparam logic [2:0] K_UNLOCK = 3'd1;
    localparam logic [2:0] K_SPAWN  = 3'd2;
    localparam logic [2:0] K_TMC    = 3'd3;
    localparam logic [2:0] K_BAR    = 3'd4;
    localparam logic [2:0] K_BRANCH = 3'd5;
    localparam logic [2:0] K_COMMIT = 3'd6;
    localparam logic [2:0] K_BUSY   = 3'd7;

    // flag is taken, is_wstall or expected busy
    typedef struct packed {
        logic [2:0] kind;
        wid_t       wid;
        logic [3:0] mask;
        pc_t        pc;
        logic       flag;
        logic       port;
        bar_id_t    bar_id;
        logic [1:0] size_m1;
        logic       rnd;
        logic [2:0] n_exp;
    } step_t;

    logic                 clk = 1'b0;
    logic                 reset;
    warp_ctl_t            warp_ctl;
    branch_t [1:0]        branch;
    dec_unlock_t          dec_unlock;
    commit_t              commit;
    logic                 sched_ready = 1'b0;
    logic                 sched_valid;
    sched_out_t           sched_data;
    logic                 busy;

    step_t                steps [NSTEPS];
    logic [31:0]          lfsr = 32'hc0b0a31e;
    logic                 rnd_mode = 1'b0;
    sched_out_t           got_q[$];
    sched_out_t           exp_q[$];
    int                   pend [NUM_WARPS];
    logic                 held = 1'b0;
    sched_out_t           held_data;

    // warp model
    wmask_t               m_active;
    wmask_t               m_stalled;
    wmask_t               m_bar;
    tmask_t               m_tmask [NUM_WARPS];
    pc_t                  m_pc [NUM_WARPS];
    wmask_t               m_members [NUM_BARRIERS];

    warp_sched #(
        .NUM_BRANCH_PORTS  (2),
        .STARTUP_PC        (BOOT_PC),
        .PENDING_CTR_WIDTH (6)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .warp_ctl    (warp_ctl),
        .branch      (branch),
        .dec_unlock  (dec_unlock),
        .commit      (commit),
        .sched_ready (sched_ready),
        .sched_valid (sched_valid),
        .sched_data  (sched_data),
        .busy        (busy)
    );

    always #10 clk = ~clk;

    task automatic stop_failed();
        $display("** FAIL **");
        $fatal(1, "simulation stopped on the first error");
    endtask

    `include "sched_check.svh"

    // ready pattern from one LFSR bit per cycle in random steps
    always @(posedge clk) begin
        if (rnd_mode) begin
            lfsr = lfsr_next(lfsr);
            sched_ready <= lfsr[0];
        end else begin
            sched_ready <= 1'b1;
        end
    end

    // transfer monitor and hold check
    always @(posedge clk) begin
        if (!reset) begin
            if (held) begin
                compare_bit(sched_valid, 1'b1, "valid under stall");
                compare_out(sched_data, held_data, "data under stall");
            end
            if (sched_valid && sched_ready) begin
                got_q.push_back(sched_data);
                pend[sched_data.wid] = pend[sched_data.wid] + 1;
            end
            held = sched_valid && !sched_ready;
            held_data = sched_data;
        end
    end

    task automatic model_apply(input step_t s);
        int cnt;
        cnt = 0;
        case (s.kind)
            K_UNLOCK: if (!s.flag) m_stalled[s.wid] = 1'b0;
            K_SPAWN: begin
                for (int i = 0; i < NUM_WARPS; i++) begin
                    if (s.mask[i]) begin
                        m_active[i] = 1'b1;
                        m_tmask[i]  = tmask_t'(1);
                        m_pc[i]     = s.pc;
                    end
                end
                m_stalled[s.wid] = 1'b0;
            end
            K_TMC: begin
                m_tmask[s.wid]   = s.mask;
                m_active[s.wid]  = (s.mask != 4'h0);
                m_stalled[s.wid] = 1'b0;
            end
            K_BAR: begin
                m_stalled[s.wid] = 1'b0;
                for (int i = 0; i < NUM_WARPS; i++) begin
                    cnt += int'(m_members[s.bar_id][i]);
                end
                // last arrival frees the whole group
                if (cnt == int'(s.size_m1)) begin
                    m_bar &= ~m_members[s.bar_id];
                    m_members[s.bar_id] = '0;
                end else begin
                    m_members[s.bar_id][s.wid] = 1'b1;
                    m_bar[s.wid] = 1'b1;
                end
            end
            K_BRANCH: begin
                if (s.flag) m_pc[s.wid] = s.pc;
                m_stalled[s.wid] = 1'b0;
            end
            default: ;
        endcase
    endtask

    // lowest ready warp first and each parks after it issues
    task automatic model_drain();
        wmask_t     rdy;
        sched_out_t e;
        rdy = m_active & ~m_stalled & ~m_bar;
        while (rdy != '0) begin
            for (int i = NUM_WARPS - 1; i >= 0; i--) begin
                if (rdy[i]) e.wid = wid_t'(i);
            end
            e.tmask = m_tmask[e.wid];
            e.pc    = m_pc[e.wid];
            exp_q.push_back(e);
            m_pc[e.wid] = m_pc[e.wid] + 32'd4;
            m_stalled[e.wid] = 1'b1;
            rdy = m_active & ~m_stalled & ~m_bar;
        end
    endtask

    // one-cycle pulse on the matching input
    task automatic drive_event(input step_t s);
        warp_ctl_t c;
        branch_t   b;
        c = '0;
        b = '0;
        c.valid = 1'b1;
        c.wid   = s.wid;
        @(posedge clk);
        case (s.kind)
            K_UNLOCK: dec_unlock <= '{valid: 1'b1, wid: s.wid, is_wstall: s.flag};
            K_SPAWN: begin
                c.spawn = '{valid: 1'b1, wmask: s.mask, pc: s.pc};
                warp_ctl <= c;
            end
            K_TMC: begin
                c.tmc = '{valid: 1'b1, tmask: s.mask};
                warp_ctl <= c;
            end
            K_BAR: begin
                c.barrier = '{valid: 1'b1, id: s.bar_id, size_m1: s.size_m1};
                warp_ctl <= c;
            end
            K_BRANCH: begin
                b = '{valid: 1'b1, wid: s.wid, taken: s.flag, dest: s.pc};
                branch[s.port] <= b;
            end
            default: ;
        endcase
        @(posedge clk);
        warp_ctl   <= '0;
        branch     <= '0;
        dec_unlock <= '0;
    endtask

    task automatic wait_transfers(input int n);
        int cycles;
        cycles = 0;
        while (got_q.size() < n) begin
            @(negedge clk);
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("timed out waiting for a schedule transfer");
                stop_failed();
            end
        end
        for (int i = 0; i < n; i++) begin
            compare_out(got_q.pop_front(), exp_q.pop_front(), "issued warp");
        end
        // nothing else may follow
        cycles = 0;
        while (cycles < 12) begin
            @(negedge clk);
            cycles++;
            if (got_q.size() != 0) begin
                $display("the scheduler issued a warp that should have stayed parked");
                stop_failed();
            end
        end
    endtask

    task automatic commit_all();
        for (int w = 0; w < NUM_WARPS; w++) begin
            while (pend[w] > 0) begin
                @(posedge clk);
                commit <= '{valid: 1'b1, wid: wid_t'(w)};
                pend[w] = pend[w] - 1;
            end
        end
        @(posedge clk);
        commit <= '0;
    endtask

    task automatic wait_busy(input logic exp);
        int cycles;
        cycles = 0;
        while (busy !== exp && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        compare_bit(busy, exp, "busy");
    endtask

    initial begin
        // kind, wid, mask, pc, flag, port, bar id, size_m1, rnd, expected issues
        steps[0]  = '{K_IDLE,   2'd0, 4'h0, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd1};
        steps[1]  = '{K_UNLOCK, 2'd0, 4'h0, 32'h0,      1'b1, 1'b0, 2'd0, 2'd0, 1'b0, 3'd0};
        steps[2]  = '{K_UNLOCK, 2'd0, 4'h0, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd1};
        steps[3]  = '{K_SPAWN,  2'd1, 4'he, 32'h1000,   1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd3};
        steps[4]  = '{K_UNLOCK, 2'd2, 4'h0, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd1};
        steps[5]  = '{K_BRANCH, 2'd1, 4'h0, 32'h2000,   1'b1, 1'b0, 2'd0, 2'd0, 1'b0, 3'd1};
        steps[6]  = '{K_BRANCH, 2'd3, 4'h0, 32'h5550,   1'b0, 1'b1, 2'd0, 2'd0, 1'b0, 3'd1};
        steps[7]  = '{K_BAR,    2'd1, 4'h0, 32'h0,      1'b0, 1'b0, 2'd1, 2'd2, 1'b0, 3'd0};
        steps[8]  = '{K_BAR,    2'd2, 4'h0, 32'h0,      1'b0, 1'b0, 2'd1, 2'd2, 1'b0, 3'd0};
        steps[9]  = '{K_BAR,    2'd3, 4'h0, 32'h0,      1'b0, 1'b0, 2'd1, 2'd2, 1'b0, 3'd3};
        steps[10] = '{K_UNLOCK, 2'd0, 4'h0, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b1, 3'd1};
        steps[11] = '{K_BAR,    2'd0, 4'h0, 32'h0,      1'b0, 1'b0, 2'd2, 2'd1, 1'b1, 3'd0};
        steps[12] = '{K_BAR,    2'd1, 4'h0, 32'h0,      1'b0, 1'b0, 2'd2, 2'd1, 1'b1, 3'd2};
        steps[13] = '{K_BRANCH, 2'd2, 4'h0, 32'h3000,   1'b1, 1'b1, 2'd0, 2'd0, 1'b1, 3'd1};
        steps[14] = '{K_TMC,    2'd0, 4'h0, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd0};
        steps[15] = '{K_TMC,    2'd1, 4'h0, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd0};
        steps[16] = '{K_TMC,    2'd2, 4'h0, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd0};
        steps[17] = '{K_TMC,    2'd3, 4'h0, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd0};
        // no warp active but instructions still pending
        steps[18] = '{K_BUSY,   2'd0, 4'h0, 32'h0,      1'b1, 1'b0, 2'd0, 2'd0, 1'b0, 3'd0};
        steps[19] = '{K_COMMIT, 2'd0, 4'h0, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd0};
        steps[20] = '{K_BUSY,   2'd0, 4'h0, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd0};
        steps[21] = '{K_TMC,    2'd2, 4'h3, 32'h0,      1'b0, 1'b0, 2'd0, 2'd0, 1'b0, 3'd1};
        steps[22] = '{K_BUSY,   2'd0, 4'h0, 32'h0,      1'b1, 1'b0, 2'd0, 2'd0, 1'b0, 3'd0};

        reset      = 1'b1;
        warp_ctl   = '0;
        branch     = '0;
        dec_unlock = '0;
        commit     = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            pend[i]    = 0;
            m_tmask[i] = '0;
            m_pc[i]    = '0;
        end
        for (int i = 0; i < NUM_BARRIERS; i++) m_members[i] = '0;
        // boot state has warp 0 on thread 0
        m_active   = wmask_t'(1);
        m_stalled  = '0;
        m_bar      = '0;
        m_tmask[0] = tmask_t'(1);
        m_pc[0]    = BOOT_PC;

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        // state left by reset
        compare_bit(busy, 1'b1, "busy after reset");
        compare_bit(sched_valid, 1'b0, "valid after reset");

        for (int k = 0; k < NSTEPS; k++) begin
            rnd_mode = steps[k].rnd;
            case (steps[k].kind)
                K_COMMIT: commit_all();
                K_BUSY:   wait_busy(steps[k].flag);
                default: begin
                    if (steps[k].kind != K_IDLE) begin
                        model_apply(steps[k]);
                        drive_event(steps[k]);
                    end
                    model_drain();
                    if (exp_q.size() != int'(steps[k].n_exp)) begin
                        $display("step %0d expects %0d issues but the model predicts %0d",
                                 k, steps[k].n_exp, exp_q.size());
                        stop_failed();
                    end
                    wait_transfers(int'(steps[k].n_exp));
                end
            endcase
        end

        $display("** PASS **");
        $finish;
    end

endmodule

// File: verilog/pending_instr.sv
// --------------------
// pending instructions
// per-warp issued but uncommitted
// counts and the scheduler busy flag
// --------------------
`timescale 1ns/1ps

module pending_instr #(
    parameter int PENDING_CTR_WIDTH = 6
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   out_fire,
    input  sched_cfg_pkg::wid_t    out_wid,
    input  sched_msg_pkg::commit_t commit,
    input  sched_cfg_pkg::wmask_t  active,
    output logic                   busy
);
    import sched_cfg_pkg::*;

    typedef logic [PENDING_CTR_WIDTH-1:0] ctr_t;

    ctr_t [NUM_WARPS-1:0] counts;
    wmask_t               nonzero;

    for (genvar i = 0; i < NUM_WARPS; i++) begin : g_ctr
        logic incr;
        logic decr;

        assign incr       = out_fire && (out_wid == wid_t'(i));
        assign decr       = commit.valid && (commit.wid == wid_t'(i));
        assign nonzero[i] = (counts[i] != '0);

        // issue and commit together leave the count alone
        always_ff @(posedge clk) begin
            if (reset) begin
                counts[i] <= '0;
            end else if (incr && !decr) begin
                counts[i] <= counts[i] + ctr_t'(1);
            end else if (decr && !incr) begin
                counts[i] <= counts[i] - ctr_t'(1);
            end
        end

        assert property (@(posedge clk) disable iff (reset) decr && !incr |-> nonzero[i])
            else $error("commit without a pending instruction");
        assert property (@(posedge clk) disable iff (reset) incr && !decr |-> counts[i] != '1)
            else $error("pending counter overflow");
    end

    // warp 0 is live out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b1;
        end else begin
            busy <= (active != '0) || (nonzero != '0);
        end
    end

endmodule

// File: verilog/warp_ctl_decode.sv
// --------------------
// warp control decode
// registers control, branch and decode
// events into one update per cycle
// --------------------
`timescale 1ns/1ps

module warp_ctl_decode #(
    parameter int NUM_BRANCH_PORTS = 2
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  sched_msg_pkg::warp_ctl_t                      warp_ctl,
    input  sched_msg_pkg::branch_t [NUM_BRANCH_PORTS-1:0] branch,
    input  sched_msg_pkg::dec_unlock_t                    dec_unlock,
    output sched_msg_pkg::warp_update_t                   upd
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    warp_update_t upd_n;
    logic         branch_conflict;

    always_comb begin
        upd_n = '0;
        upd_n.ctl = warp_ctl;
        // group valids only count under the event valid
        upd_n.ctl.spawn.valid   = warp_ctl.valid && warp_ctl.spawn.valid;
        upd_n.ctl.tmc.valid     = warp_ctl.valid && warp_ctl.tmc.valid;
        upd_n.ctl.barrier.valid = warp_ctl.valid && warp_ctl.barrier.valid;
        // unused branch slots stay zero
        for (int i = 0; i < NUM_BRANCH_PORTS; i++) begin
            upd_n.branch[i] = branch[i];
        end
        // wstall unlocks keep the warp parked
        upd_n.unlock.valid = dec_unlock.valid && !dec_unlock.is_wstall;
        upd_n.unlock.wid   = dec_unlock.wid;
    end

    always_ff @(posedge clk) begin
        upd <= upd_n;
        if (reset) begin
            upd.ctl.valid         <= 1'b0;
            upd.ctl.spawn.valid   <= 1'b0;
            upd.ctl.tmc.valid     <= 1'b0;
            upd.ctl.barrier.valid <= 1'b0;
            upd.unlock.valid      <= 1'b0;
            for (int i = 0; i < MAX_BRANCH_PORTS; i++) begin
                upd.branch[i].valid <= 1'b0;
            end
        end
    end

    // two ALU ports never resolve the same warp together
    always_comb begin
        branch_conflict = 1'b0;
        for (int i = 0; i < NUM_BRANCH_PORTS; i++) begin
            for (int j = i + 1; j < NUM_BRANCH_PORTS; j++) begin
                if (branch[i].valid && branch[j].valid && branch[i].wid == branch[j].wid) begin
                    branch_conflict = 1'b1;
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (reset) !branch_conflict)
        else $error("two branch ports name the same warp");

endmodule

// File: verilog/warp_issue.sv
// --------------------
// warp issue
// picks the lowest ready warp and holds
// it in a two-entry output skid buffer
// --------------------
`timescale 1ns/1ps

module warp_issue (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  sched_cfg_pkg::wmask_t                                 active,
    input  sched_cfg_pkg::wmask_t                                 stalled,
    input  sched_cfg_pkg::wmask_t                                 bar_stalls,
    input  sched_cfg_pkg::tmask_t [sched_cfg_pkg::NUM_WARPS-1:0] tmasks,
    input  sched_cfg_pkg::pc_t [sched_cfg_pkg::NUM_WARPS-1:0]    pcs,
    input  logic                                                  sched_ready,
    output logic                                                  sel_fire,
    output sched_cfg_pkg::wid_t                                   sel_wid,
    output logic                                                  out_fire,
    output logic                                                  sched_valid,
    output sched_msg_pkg::sched_out_t                             sched_data
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    wmask_t           ready_warps;
    logic             any_ready;
    sched_out_t       sel_data;
    sched_out_t [1:0] entries;
    logic [1:0]       count;
    // entries left after this cycle's pop
    logic [1:0]       kept;

    assign ready_warps = active & ~(stalled | bar_stalls);

    // scan downward so the lowest index wins
    always_comb begin
        any_ready = 1'b0;
        sel_wid   = '0;
        for (int i = NUM_WARPS - 1; i >= 0; i--) begin
            if (ready_warps[i]) begin
                any_ready = 1'b1;
                sel_wid   = wid_t'(i);
            end
        end
    end

    always_comb begin
        sel_data.wid   = sel_wid;
        sel_data.tmask = tmasks[sel_wid];
        sel_data.pc    = pcs[sel_wid];
    end

    assign sched_valid = (count != 2'd0);
    assign sched_data  = entries[0];
    assign out_fire    = sched_valid && sched_ready;
    // a full buffer still accepts when the head leaves
    assign sel_fire    = any_ready && (count != 2'd2 || out_fire);
    assign kept        = count - {1'b0, out_fire};

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= '0;
        end else begin
            count <= kept + {1'b0, sel_fire};
        end
    end

    always_ff @(posedge clk) begin
        if (out_fire) begin
            entries[0] <= entries[1];
        end
        if (sel_fire) begin
            if (kept == 2'd0) begin
                entries[0] <= sel_data;
            end else begin
                entries[1] <= sel_data;
            end
        end
    end

    // output holds while the consumer stalls
    assert property (@(posedge clk) disable iff (reset)
        sched_valid && !sched_ready |=> sched_valid && $stable(sched_data))
        else $error("schedule output changed while stalled");

endmodule

// File: verilog/warp_sched.sv
// --------------------
// warp scheduler
// top level of the SIMT warp scheduler
// --------------------
`timescale 1ns/1ps

module warp_sched #(
    parameter int                 NUM_BRANCH_PORTS  = 2,
    parameter sched_cfg_pkg::pc_t STARTUP_PC        = 32'h8000_0000,
    parameter int                 PENDING_CTR_WIDTH = 6
) (
    input  logic                                          clk,
    input  logic                                          reset,
    input  sched_msg_pkg::warp_ctl_t                      warp_ctl,
    input  sched_msg_pkg::branch_t [NUM_BRANCH_PORTS-1:0] branch,
    input  sched_msg_pkg::dec_unlock_t                    dec_unlock,
    input  sched_msg_pkg::commit_t                        commit,
    input  logic                                          sched_ready,
    output logic                                          sched_valid,
    output sched_msg_pkg::sched_out_t                     sched_data,
    output logic                                          busy
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    warp_update_t           upd;
    wmask_t                 active;
    wmask_t                 stalled;
    wmask_t                 bar_stalls;
    tmask_t [NUM_WARPS-1:0] tmasks;
    pc_t [NUM_WARPS-1:0]    pcs;
    logic                   sel_fire;
    wid_t                   sel_wid;
    logic                   out_fire;

    warp_ctl_decode #(
        .NUM_BRANCH_PORTS (NUM_BRANCH_PORTS)
    ) u_decode (
        .clk        (clk),
        .reset      (reset),
        .warp_ctl   (warp_ctl),
        .branch     (branch),
        .dec_unlock (dec_unlock),
        .upd        (upd)
    );

    warp_table #(
        .STARTUP_PC (STARTUP_PC)
    ) u_table (
        .clk      (clk),
        .reset    (reset),
        .upd      (upd),
        .sel_fire (sel_fire),
        .sel_wid  (sel_wid),
        .out_fire (out_fire),
        .out_data (sched_data),
        .active   (active),
        .stalled  (stalled),
        .tmasks   (tmasks),
        .pcs      (pcs)
    );

    barrier_unit u_barrier (
        .clk        (clk),
        .reset      (reset),
        .upd        (upd),
        .bar_stalls (bar_stalls)
    );

    warp_issue u_issue (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .stalled     (stalled),
        .bar_stalls  (bar_stalls),
        .tmasks      (tmasks),
        .pcs         (pcs),
        .sched_ready (sched_ready),
        .sel_fire    (sel_fire),
        .sel_wid     (sel_wid),
        .out_fire    (out_fire),
        .sched_valid (sched_valid),
        .sched_data  (sched_data)
    );

    pending_instr #(
        .PENDING_CTR_WIDTH (PENDING_CTR_WIDTH)
    ) u_pending (
        .clk      (clk),
        .reset    (reset),
        .out_fire (out_fire),
        .out_wid  (sched_data.wid),
        .commit   (commit),
        .active   (active),
        .busy     (busy)
    );

endmodule

// File: warp_table/barrier_unit.sv
// --------------------
// barrier unit
// local barrier membership and the
// per-warp barrier stall flags
// --------------------
`timescale 1ns/1ps

module barrier_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  sched_msg_pkg::warp_update_t upd,
    output sched_cfg_pkg::wmask_t       bar_stalls
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    wmask_t [NUM_BARRIERS-1:0] bar_masks;
    wmask_t [NUM_BARRIERS-1:0] bar_masks_n;
    wmask_t                    bar_stalls_n;
    wmask_t                    cur_mask;
    wcount_t                   member_cnt;

    always_comb begin
        cur_mask = bar_masks[upd.ctl.barrier.id];
        // warps already waiting here
        member_cnt = '0;
        for (int i = 0; i < NUM_WARPS; i++) begin
            member_cnt += wcount_t'(cur_mask[i]);
        end

        bar_masks_n  = bar_masks;
        bar_stalls_n = bar_stalls;
        if (upd.ctl.barrier.valid) begin
            if (member_cnt == wcount_t'(upd.ctl.barrier.size_m1)) begin
                // last arrival releases everyone and does not wait
                bar_masks_n[upd.ctl.barrier.id] = '0;
                bar_stalls_n &= ~cur_mask;
            end else begin
                bar_masks_n[upd.ctl.barrier.id][upd.ctl.wid] = 1'b1;
                bar_stalls_n[upd.ctl.wid] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            bar_masks  <= '0;
            bar_stalls <= '0;
        end else begin
            bar_masks  <= bar_masks_n;
            bar_stalls <= bar_stalls_n;
        end
    end

endmodule

// File: warp_table/warp_table.sv
// --------------------
// warp table
// per-warp active, stall, thread mask
// and PC state, updated in priority order
// --------------------
`timescale 1ns/1ps

module warp_table #(
    parameter sched_cfg_pkg::pc_t STARTUP_PC = 32'h8000_0000
) (
    input  logic                                                  clk,
    input  logic                                                  reset,
    input  sched_msg_pkg::warp_update_t                           upd,
    input  logic                                                  sel_fire,
    input  sched_cfg_pkg::wid_t                                   sel_wid,
    input  logic                                                  out_fire,
    input  sched_msg_pkg::sched_out_t                             out_data,
    output sched_cfg_pkg::wmask_t                                 active,
    output sched_cfg_pkg::wmask_t                                 stalled,
    output sched_cfg_pkg::tmask_t [sched_cfg_pkg::NUM_WARPS-1:0] tmasks,
    output sched_cfg_pkg::pc_t [sched_cfg_pkg::NUM_WARPS-1:0]    pcs
);
    import sched_cfg_pkg::*;
    import sched_msg_pkg::*;

    wmask_t                  active_n;
    wmask_t                  stalled_n;
    tmask_t [NUM_WARPS-1:0]  tmasks_n;
    pc_t [NUM_WARPS-1:0]     pcs_n;
    // warps whose PC is rewritten by a spawn or a taken branch
    wmask_t                  redirect;

    always_comb begin
        active_n  = active;
        stalled_n = stalled;
        tmasks_n  = tmasks;
        pcs_n     = pcs;
        redirect  = '0;

        // spawn, masked warps start on one thread
        if (upd.ctl.spawn.valid) begin
            active_n |= upd.ctl.spawn.wmask;
            for (int i = 0; i < NUM_WARPS; i++) begin
                if (upd.ctl.spawn.wmask[i]) begin
                    tmasks_n[i] = tmask_t'(1);
                    pcs_n[i]    = upd.ctl.spawn.pc;
                end
            end
            redirect |= upd.ctl.spawn.wmask;
            stalled_n[upd.ctl.wid] = 1'b0;
        end

        // tmc, an empty mask retires the warp
        if (upd.ctl.tmc.valid) begin
            active_n[upd.ctl.wid]  = (upd.ctl.tmc.tmask != '0);
            tmasks_n[upd.ctl.wid]  = upd.ctl.tmc.tmask;
            stalled_n[upd.ctl.wid] = 1'b0;
        end

        // barrier stalls are held in the barrier unit
        if (upd.ctl.barrier.valid) begin
            stalled_n[upd.ctl.wid] = 1'b0;
        end

        for (int i = 0; i < MAX_BRANCH_PORTS; i++) begin
            if (upd.branch[i].valid) begin
                if (upd.branch[i].taken) begin
                    pcs_n[upd.branch[i].wid]    = upd.branch[i].dest;
                    redirect[upd.branch[i].wid] = 1'b1;
                end
                stalled_n[upd.branch[i].wid] = 1'b0;
            end
        end

        if (upd.unlock.valid) begin
            stalled_n[upd.unlock.wid] = 1'b0;
        end

        // hold the picked warp until decode releases it
        if (sel_fire) begin
            stalled_n[sel_wid] = 1'b1;
        end

        // sequential PC unless redirected this cycle
        if (out_fire && !redirect[out_data.wid]) begin
            pcs_n[out_data.wid] = out_data.pc + pc_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            // warp 0 boots on thread 0
            active     <= wmask_t'(1);
            stalled    <= '0;
            tmasks     <= '0;
            tmasks[0]  <= tmask_t'(1);
            pcs        <= '0;
            pcs[0]     <= STARTUP_PC;
        end else begin
            active  <= active_n;
            stalled <= stalled_n;
            tmasks  <= tmasks_n;
            pcs     <= pcs_n;
        end
    end

endmodule
